//--- Bender.yml
package:
  name: injector

sources:
  - files:
      - hw/injector_pkg.sv
      - hw/setting_panel.sv
      - hw/packet_injector.sv
      - hw/seven_seg_decoder.sv
      - hw/injector_top.sv
  - target: test
    files:
      - testbench/injector_properties.sv
      - testbench/injector_tb.sv

//--- all.f
hw/injector_pkg.sv
hw/setting_panel.sv
hw/packet_injector.sv
hw/seven_seg_decoder.sv
hw/injector_top.sv
testbench/injector_properties.sv
testbench/injector_tb.sv

//--- hw/injector_pkg.sv
`default_nettype none

package injector_pkg;

	// ====================
	// packet layout
	// ====================

	localparam int step_width    = 8;                 // one mesh step count
	localparam int setting_width = 2 * step_width;    // two step counts side by side
	localparam int packet_width  = 1 + setting_width; // valid bit on top of the payload

	localparam int packet_valid_bit = packet_width - 1; // msb of each router slot

	// ====================
	// seven-segment display
	// ====================

	// segments a..g from high bit to low, a lit segment is driven 0
	typedef logic [6:0] seg_t;

	localparam int num_digits = 10;

	localparam seg_t seg_blank = 7'b111_1111; // every segment dark

	localparam seg_t seg_digits [num_digits] = '{
		~7'b111_1110, // 0
		~7'b011_0000, // 1
		~7'b110_1101, // 2
		~7'b111_1001, // 3
		~7'b011_0011, // 4
		~7'b101_1011, // 5
		~7'b101_1111, // 6
		~7'b111_0000, // 7
		~7'b111_1111, // 8
		~7'b111_1011  // 9
	};

endpackage

`default_nettype wire

//--- hw/injector_top.sv
`default_nettype none

module injector_top
	import injector_pkg::*;
#(
	parameter int num_routers = 225
)
(
	input  wire                                      clk,
	input  wire                                      arst_n,
	input  wire                                      enable,     // send packet to the mesh
	input  wire                                      sel_data,   // keys step the data value
	input  wire                                      sel_router, // keys step the router number
	input  wire                                      key_inc,
	input  wire                                      key_dec,
	output logic [num_routers-1:0][packet_width-1:0] router_packets,
	output seg_t                                     hex_data,
	output seg_t                                     hex_router
);

	logic [setting_width-1:0] data_value;
	logic [setting_width-1:0] router_index;

	// ====================
	// operator panel
	// ====================

	setting_panel u_setting_panel (
		.clk          (clk),
		.arst_n       (arst_n),
		.sel_data     (sel_data),
		.sel_router   (sel_router),
		.key_inc      (key_inc),
		.key_dec      (key_dec),
		.data_value   (data_value),
		.router_index (router_index)
	);

	// ====================
	// mesh injection
	// ====================

	packet_injector #(
		.num_routers (num_routers)
	) u_packet_injector (
		.clk            (clk),
		.arst_n         (arst_n),
		.enable         (enable),
		.data_value     (data_value),
		.router_index   (router_index),
		.router_packets (router_packets)
	);

	// ====================
	// displays
	// ====================

	seven_seg_decoder data_display (
		.clk      (clk),
		.arst_n   (arst_n),
		.value    (data_value),
		.segments (hex_data)
	);

	seven_seg_decoder router_display (
		.clk      (clk),
		.arst_n   (arst_n),
		.value    (router_index),
		.segments (hex_router)
	);

endmodule

`default_nettype wire

//--- hw/packet_injector.sv
`default_nettype none

module packet_injector
	import injector_pkg::*;
#(
	parameter int num_routers = 225
)
(
	input  wire                                      clk,
	input  wire                                      arst_n,
	input  wire                                      enable,       // injection switch
	input  wire  [setting_width-1:0]                 data_value,   // payload to send
	input  wire  [setting_width-1:0]                 router_index, // target slot
	output logic [num_routers-1:0][packet_width-1:0] router_packets
);

	// ====================
	// elaboration checks
	// ====================

	if (num_routers < 1)
	begin : g_too_few
		$error("packet_injector needs at least one router slot");
	end

	if (num_routers > 2 ** setting_width)
	begin : g_too_many
		$error("router_index cannot reach every router slot");
	end

	// ====================
	// one-hot fan-out
	// ====================

	logic [num_routers-1:0][packet_width-1:0] packets_next;

	// an index past the last slot matches nothing, so all slots stay zero
	always_comb
	begin
		packets_next = '0;
		if (enable)
		begin
			for (int i = 0; i < num_routers; i++)
			begin
				if (int'(router_index) == i)
				begin
					packets_next[i][packet_valid_bit]    = 1'b1;
					packets_next[i][setting_width-1:0] = data_value;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			router_packets <= '0;
		end
		else
		begin
			router_packets <= packets_next; // one cycle behind the settings
		end
	end

endmodule

`default_nettype wire

//--- hw/setting_panel.sv
`default_nettype none

module setting_panel
	import injector_pkg::*;
(
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire                      sel_data,     // key steps change the data value
	input  wire                      sel_router,   // key steps change the router number
	input  wire                      key_inc,      // push key, count up
	input  wire                      key_dec,      // push key, count down
	output logic [setting_width-1:0] data_value,
	output logic [setting_width-1:0] router_index
);

	// ====================
	// key press detection
	// ====================

	logic key_inc_q; // key level seen at the previous edge
	logic key_dec_q;
	logic inc_press;
	logic dec_press;

	// sampled every cycle, even with no register selected,
	// so a key held while the switches move still counts once
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			key_inc_q <= 1'b0;
			key_dec_q <= 1'b0;
		end
		else
		begin
			key_inc_q <= key_inc;
			key_dec_q <= key_dec;
		end
	end

	assign inc_press = key_inc & ~key_inc_q; // high now, low one sample before
	assign dec_press = key_dec & ~key_dec_q;

	// ====================
	// step amount
	// ====================

	logic [setting_width-1:0] step_value; // two's complement +1, -1 or 0

	always_comb
	begin
		case ({inc_press, dec_press})
			2'b10:   step_value = setting_width'(1); // up by one
			2'b01:   step_value = '1;                // down by one
			default: step_value = '0;                // idle, or both keys cancel
		endcase
	end

	// ====================
	// setting registers
	// ====================

	// both wrap modulo 2**setting_width through plain adder overflow
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			data_value <= '0;
		end
		else if (sel_data)
		begin
			data_value <= data_value + step_value;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			router_index <= '0;
		end
		else if (sel_router)
		begin
			router_index <= router_index + step_value;
		end
	end

endmodule

`default_nettype wire

//--- hw/seven_seg_decoder.sv
`default_nettype none

module seven_seg_decoder
	import injector_pkg::*;
(
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire  [setting_width-1:0] value,   // number to show
	output seg_t                     segments // active low, a..g
);

	// ====================
	// digit lookup
	// ====================

	logic in_range; // value fits one decimal digit
	seg_t pattern;

	assign in_range = (value < setting_width'(num_digits));

	always_comb
	begin
		if (in_range)
		begin
			pattern = seg_digits[value[3:0]];
		end
		else
		begin
			pattern = seg_blank; // two-digit values are not shown
		end
	end

	// ====================
	// output register
	// ====================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			segments <= seg_blank; // dark until the first decode
		end
		else
		begin
			segments <= pattern;
		end
	end

endmodule

`default_nettype wire

//--- testbench/injector_properties.sv
`default_nettype none

module injector_properties
	import injector_pkg::*;
#(
	parameter int num_routers = 225
)
(
	input wire                                     clk,
	input wire                                     arst_n,
	input wire                                     enable,
	input wire [num_routers-1:0][packet_width-1:0] router_packets,
	input wire [6:0]                               hex_data,
	input wire [6:0]                               hex_router
);

	int fail_count = 0;

	logic [num_routers-1:0] valid_bits; // top bit of every slot

	always_comb
	begin
		for (int i = 0; i < num_routers; i++)
			valid_bits[i] = router_packets[i][packet_valid_bit];
	end

	// ====================
	// properties
	// ====================

	single_target: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(valid_bits))
	else
	begin
		$error("more than one router slot holds a valid packet");
		fail_count++;
	end

	cleared_when_off: assert property (@(posedge clk) disable iff (!arst_n)
		!enable |=> (router_packets == '0))
	else
	begin
		$error("router slots not cleared after enable went low");
		fail_count++;
	end

	known_displays: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(hex_data) && !$isunknown(hex_router))
	else
	begin
		$error("display segments unknown");
		fail_count++;
	end

endmodule

bind injector_top injector_properties #(
	.num_routers (num_routers)
) u_properties (
	.clk            (clk),
	.arst_n         (arst_n),
	.enable         (enable),
	.router_packets (router_packets),
	.hex_data       (hex_data),
	.hex_router     (hex_router)
);

`default_nettype wire

//--- testbench/injector_tb.sv
`default_nettype none

module injector_tb
	import injector_pkg::*;
();

	// ====================
	// settings of the run
	// ====================

	localparam int num_routers = 12;
	localparam int clk_period  = 20;
	localparam int reset_cycles = 8;
	localparam int num_steps   = 24;
	localparam int step_cycles = 8;  // longest hold, release and idle gap together
	localparam int watchdog_time = num_steps * step_cycles * clk_period * 4;

	typedef struct packed {
		logic                     enable;
		logic                     sel_data;
		logic                     sel_router;
		logic                     key_inc;
		logic                     key_dec;
		logic [1:0]               hold;       // cycles the keys stay down
		logic [setting_width-1:0] exp_data;
		logic [setting_width-1:0] exp_router;
	} step_t;

	// en, sel_data, sel_router, inc, dec, hold, data, router
	localparam step_t steps [num_steps] = '{
		'{1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 2'd1, 16'hffff, 16'd0},    // data wraps below 0
		'{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 2'd1, 16'd0,    16'd0},
		'{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 2'd1, 16'd0,    16'hffff}, // no slot matches
		'{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 2'd1, 16'd0,    16'd0},
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd3, 16'd1,    16'd1},    // held key, one step
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd2,    16'd2},
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd3,    16'd3},
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd4,    16'd4},
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd5,    16'd5},
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd6,    16'd6},
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd7,    16'd7},
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd8,    16'd8},
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd9,    16'd9},
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd10,   16'd10},   // displays go blank
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd11,   16'd11},   // last slot
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 2'd1, 16'd12,   16'd12},   // one past the last slot
		'{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 2'd1, 16'd12,   16'd11},
		'{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 2'd1, 16'd12,   16'd10},
		'{1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 2'd1, 16'd11,   16'd10},
		'{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 2'd1, 16'd11,   16'd10},   // enable off
		'{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 2'd1, 16'd11,   16'd10},   // enable back on
		'{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 2'd1, 16'd11,   16'd10},   // nothing selected
		'{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 2'd1, 16'd11,   16'd10},   // keys cancel
		'{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 2'd3, 16'd10,   16'd9}
	};

	logic                                     clk = 1'b0;
	logic                                     arst_n;
	logic                                     enable;
	logic                                     sel_data;
	logic                                     sel_router;
	logic                                     key_inc;
	logic                                     key_dec;
	logic [num_routers-1:0][packet_width-1:0] router_packets;
	seg_t                                     hex_data;
	seg_t                                     hex_router;

	int          checks = 0;
	int          errors = 0;
	logic [31:0] rng_state = 32'd16;

	injector_top #(
		.num_routers (num_routers)
	) UUT (
		.clk            (clk),
		.arst_n         (arst_n),
		.enable         (enable),
		.sel_data       (sel_data),
		.sel_router     (sel_router),
		.key_inc        (key_inc),
		.key_dec        (key_dec),
		.router_packets (router_packets),
		.hex_data       (hex_data),
		.hex_router     (hex_router)
	);

	always #(clk_period / 2) clk = ~clk;

	// ====================
	// reference model
	// ====================

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic seg_t expected_segments(input logic [setting_width-1:0] value);
		if (value < num_digits)
			return seg_digits[int'(value)];
		return seg_blank; // two digits do not fit
	endfunction

	function automatic logic [packet_width-1:0] expected_packet(
		input int                       slot,
		input logic                     en,
		input logic [setting_width-1:0] data,
		input logic [setting_width-1:0] router
	);
		if (en && int'(router) == slot)
			return {1'b1, data};
		return '0;
	endfunction

	// ====================
	// checks
	// ====================

	task automatic compare_segments(input string name, input seg_t actual, input seg_t expected);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_packets(
		input logic                     en,
		input logic [setting_width-1:0] data,
		input logic [setting_width-1:0] router
	);
		logic [packet_width-1:0] want;
		for (int i = 0; i < num_routers; i++)
		begin
			want = expected_packet(i, en, data, router);
			checks++;
			assert (router_packets[i] === want)
			else
			begin
				$display("ERROR at %0t: router_packets[%0d] expected %h, got %h",
					$time, i, want, router_packets[i]);
				errors++;
			end
		end
	endtask

	task automatic check_outputs(
		input logic                     en,
		input logic [setting_width-1:0] data,
		input logic [setting_width-1:0] router
	);
		compare_segments("hex_data", hex_data, expected_segments(data));
		compare_segments("hex_router", hex_router, expected_segments(router));
		compare_packets(en, data, router);
	endtask

	// one table entry, keys down for hold cycles, then released
	task automatic run_step(input step_t s);
		enable     = s.enable;
		sel_data   = s.sel_data;
		sel_router = s.sel_router;
		key_inc    = s.key_inc;
		key_dec    = s.key_dec;
		repeat (s.hold) @(negedge clk);
		key_inc = 1'b0;
		key_dec = 1'b0;
		@(negedge clk); // outputs follow two edges after the press
		check_outputs(s.enable, s.exp_data, s.exp_router);
	endtask

	// ====================
	// main sequence
	// ====================

	initial
	begin
		int idle_cycles;
		arst_n     = 1'b0;
		enable     = 1'b0;
		sel_data   = 1'b0;
		sel_router = 1'b0;
		key_inc    = 1'b0;
		key_dec    = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		arst_n = 1'b1;

		compare_segments("hex_data", hex_data, seg_blank); // still the reset value
		compare_segments("hex_router", hex_router, seg_blank);
		compare_packets(1'b0, '0, '0);
		@(negedge clk);
		check_outputs(1'b0, '0, '0); // first decode shows 0

		for (int k = 0; k < num_steps; k++)
		begin
			run_step(steps[k]);
			rng_state   = next_random(rng_state);
			idle_cycles = int'(rng_state[1:0]);
			if (idle_cycles > 0)
			begin
				repeat (idle_cycles) @(negedge clk);
				check_outputs(steps[k].enable, steps[k].exp_data, steps[k].exp_router);
			end
		end

		$display("checks: %0d, check errors: %0d, property failures: %0d",
			checks, errors, UUT.u_properties.fail_count);
		if (errors == 0 && UUT.u_properties.fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// ====================
	// watchdog
	// ====================

	initial
	begin
		#(watchdog_time);
		$display("the run did not finish in %0d time units", watchdog_time);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
